//--- common/fp16_pkg.sv
`default_nettype none

package fp16_pkg;

  localparam int INT_W        = 16;
  localparam int FP16_EXP_W   = 5;
  localparam int FP16_MAN_W   = 10;
  localparam int FP16_W       = 1 + FP16_EXP_W + FP16_MAN_W;
  localparam int FP16_BIAS    = 15;
  localparam int LZC_W        = $clog2(INT_W) + 1; // 0..16 needs 5 bits
  localparam int BUF_LOC_SIZE = 4;   // fp16 words per location
  localparam int BUF_AWIDTH   = 4;   // 16 locations

  typedef logic signed [INT_W-1:0] int_word_t;
  typedef logic [FP16_W-1:0]       fp16_t;
  typedef logic [FP16_EXP_W-1:0]   exp_t;
  // leading one at bit 15, then 10 fraction bits, then 5 rounding bits
  typedef logic [INT_W-1:0]        mant_t;
  typedef logic [LZC_W-1:0]        lzc_t;
  typedef logic [BUF_AWIDTH-1:0]   buf_addr_t;
  typedef logic [BUF_LOC_SIZE*FP16_W-1:0] buf_word_t;

endpackage

`default_nettype wire

//--- common/norm_if.sv
`default_nettype none

// normalized word between the two converter stages
interface norm_if import fp16_pkg::*; ();

  logic  valid;
  logic  last;
  logic  sign;
  logic  zero;
  exp_t  exp;
  mant_t mant;

  modport source (output valid, last, sign, zero, exp, mant);
  modport sink   (input  valid, last, sign, zero, exp, mant);

endinterface

`default_nettype wire

//--- logic/lead_zero_count.sv
`default_nettype none

module lead_zero_count import fp16_pkg::*; (
  input  logic [INT_W-1:0] mag,
  output lzc_t             count
);

  logic       all_zero;
  logic       z8;
  logic       z4;
  logic       z2;
  logic [7:0] half;
  logic [3:0] quarter;
  logic       pair_msb;

  assign all_zero = (mag == '0);

  assign z8       = (mag[15:8] == 8'b0);   // upper half empty
  assign half     = z8 ? mag[7:0] : mag[15:8];
  assign z4       = (half[7:4] == 4'b0);
  assign quarter  = z4 ? half[3:0] : half[7:4];
  assign z2       = (quarter[3:2] == 2'b0);
  assign pair_msb = z2 ? quarter[1] : quarter[3];

  // tree bits only valid for a nonzero input
  assign count = all_zero ? lzc_t'(INT_W) : {1'b0, z8, z4, z2, ~pair_msb};

endmodule

`default_nettype wire

//--- fp16_convert/int_normalize.sv
`default_nettype none

module int_normalize import fp16_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      in_valid,
  input  int_word_t in_data,
  input  logic      in_last,
  norm_if.source    norm
);

  logic [INT_W-1:0] mag;
  lzc_t             lzc;
  mant_t            shifted;
  exp_t             exp_c;

  // -32768 wraps to 0x8000 and reads as unsigned 32768
  assign mag = in_data[INT_W-1] ? (~in_data + 1'b1) : in_data;

  lead_zero_count u_lzc (
    .mag   (mag),
    .count (lzc)
  );

  assign shifted = mag << lzc;
  // exponent of a word whose leading one is already at bit 15
  assign exp_c   = exp_t'(INT_W - 1 + FP16_BIAS) - lzc;    // don't care when zero

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      norm.valid <= 1'b0;
      norm.last  <= 1'b0;
    end else begin
      norm.valid <= in_valid;
      norm.last  <= in_valid & in_last;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      norm.sign <= in_data[INT_W-1];
      norm.zero <= (mag == '0);
      norm.exp  <= exp_c;
      norm.mant <= shifted;
    end
  end

endmodule

`default_nettype wire

//--- fp16_convert/round_pack.sv
`default_nettype none

module round_pack import fp16_pkg::*; (
  input  logic  clk,
  input  logic  arst_n,
  norm_if.sink  norm,
  output logic  out_valid,
  output fp16_t out_data,
  output logic  out_last
);

  logic                  guard;
  logic                  rnd;
  logic                  sticky;
  logic                  round_up;
  logic [FP16_MAN_W-1:0] frac;
  logic [FP16_MAN_W:0]   frac_inc;
  logic                  carry;
  exp_t                  exp_r;
  fp16_t                 word;

  assign frac   = norm.mant[14:5];    // leading one at bit 15 is implicit
  assign guard  = norm.mant[4];
  assign rnd    = norm.mant[3];
  assign sticky = |norm.mant[2:0];

  // nearest even, a tie only goes up when the lsb is odd
  assign round_up = guard & (rnd | sticky | frac[0]);

  assign frac_inc = {1'b0, frac} + round_up;
  assign carry    = frac_inc[FP16_MAN_W];

  // carry leaves the fraction at zero, one octave up
  assign exp_r = norm.exp + carry;

  assign word = norm.zero ? '0 : {norm.sign, exp_r, frac_inc[FP16_MAN_W-1:0]};

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
      out_last  <= 1'b0;
    end else begin
      out_valid <= norm.valid;
      out_last  <= norm.valid & norm.last;
    end
  end

  always_ff @(posedge clk) begin
    if (norm.valid) out_data <= word;
  end

endmodule

`default_nettype wire

//--- fp16_convert/int_to_fp16.sv
`default_nettype none

module int_to_fp16 import fp16_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      in_valid,
  input  int_word_t in_data,
  input  logic      in_last,
  output logic      out_valid,
  output fp16_t     out_data,
  output logic      out_last
);

  norm_if u_norm ();

  // stage 1
  int_normalize u_normalize (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_valid (in_valid),
    .in_data  (in_data),
    .in_last  (in_last),
    .norm     (u_norm.source)
  );

  // stage 2
  round_pack u_round (
    .clk       (clk),
    .arst_n    (arst_n),
    .norm      (u_norm.sink),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_last  (out_last)
  );

endmodule

`default_nettype wire

//--- logic/word_packer.sv
`default_nettype none

module word_packer import fp16_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      in_valid,
  input  fp16_t     in_data,
  input  logic      in_last,
  output logic      wr_en,
  output buf_addr_t wr_addr,
  output buf_word_t wr_data
);

  logic [$clog2(BUF_LOC_SIZE)-1:0] slot;
  buf_word_t                       stage;
  buf_word_t                       merged;
  buf_addr_t                       addr;
  logic                            flush;

  // staging plus the incoming word in its slot
  always_comb begin
    merged = stage;
    merged[slot*FP16_W +: FP16_W] = in_data;
  end

  // group complete, or sentence ends early
  assign flush = in_valid && (in_last || (slot == BUF_LOC_SIZE - 1));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      slot    <= '0;
      stage   <= '0;   // unused slots must read as zero
      addr    <= '0;
      wr_en   <= 1'b0;
      wr_addr <= '0;
    end else begin
      wr_en <= flush;
      if (flush) begin
        slot    <= '0;
        stage   <= '0;
        wr_addr <= addr;
        addr    <= in_last ? '0 : addr + 1'b1; // wraps at 16
      end else if (in_valid) begin
        slot  <= slot + 1'b1;
        stage <= merged;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (flush) wr_data <= merged;
  end

endmodule

`default_nettype wire

//--- logic/conv_top.sv
`default_nettype none

module conv_top import fp16_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      in_valid,
  input  int_word_t in_data,
  input  logic      in_last,
  output logic      wr_en,
  output buf_addr_t wr_addr,
  output buf_word_t wr_data
);

  logic  cv_valid;
  fp16_t cv_data;
  logic  cv_last;

  int_to_fp16 u_convert (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .in_last   (in_last),
    .out_valid (cv_valid),
    .out_data  (cv_data),
    .out_last  (cv_last)
  );

  // four fp16 words per buffer location
  word_packer u_packer (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_valid (cv_valid),
    .in_data  (cv_data),
    .in_last  (cv_last),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data)
  );

endmodule

`default_nettype wire

//--- bench/clock_gen.sv
`default_nettype none

module clock_gen (
  input  logic rst_req,   // extra reset from the testbench
  output logic clk,
  output logic arst_n
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int RESET_CYCLES = 16;

  logic por_n;

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;   // 20 ns period
  end

  // release just after an edge, like the other inputs
  initial begin
    por_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2 por_n = 1'b1;
  end

  assign arst_n = por_n & ~rst_req;

endmodule

`default_nettype wire

//--- bench/conv_checker.sv
`default_nettype none

module conv_checker import fp16_pkg::*; (
  input logic      clk,
  input logic      arst_n,
  input logic      in_valid,
  input int_word_t in_data,
  input logic      in_last,
  input logic      wr_en,
  input buf_addr_t wr_addr,
  input buf_word_t wr_data
);
  timeunit 1ns;
  timeprecision 1ps;

  buf_addr_t   addr_q[$];
  buf_word_t   data_q[$];
  buf_word_t   group = '0;
  int          slot = 0;
  buf_addr_t   next_addr = '0;
  int unsigned errors = 0;
  int unsigned writes = 0;
  int unsigned tests = 0;
  int unsigned test_errors = 0;
  int unsigned test_writes = 0;

  // exact integer, rounded to 11 significant bits, ties to even
  function automatic fp16_t to_fp16(input int_word_t v);
    int mag;
    int top;
    int sh;
    int frac;
    int rem;
    int half;
    if (v == 0) return '0;
    mag = (v < 0) ? -int'(v) : int'(v);
    top = 0;
    for (int b = 0; b < 16; b++) begin
      if (mag[b]) top = b;
    end
    if (top <= 10) begin
      frac = mag << (10 - top);
    end else begin
      sh   = top - 10;
      frac = mag >> sh;
      rem  = mag & ((1 << sh) - 1);
      half = 1 << (sh - 1);
      if (rem > half || (rem == half && frac[0])) frac++;
      if (frac == 2048) begin   // rounded up to the next power of two
        frac = 1024;
        top++;
      end
    end
    return {v < 0, 5'(top + 15), 10'(frac)};
  endfunction

  task automatic note_error(input string msg);
    $display("%s", msg);
    errors++;
    test_errors++;
  endtask

  task automatic check_write();
    buf_addr_t exp_addr;
    buf_word_t exp_data;
    if (wr_en === 1'b0) return;
    if (wr_en !== 1'b1) begin
      note_error($sformatf("t=%0t wr_en is unknown", $time));
      return;
    end
    writes++;
    test_writes++;
    if (addr_q.size() == 0) begin
      note_error($sformatf("t=%0t write to address %0d with no location expected",
                           $time, wr_addr));
      return;
    end
    exp_addr = addr_q.pop_front();
    exp_data = data_q.pop_front();
    if (wr_addr !== exp_addr)
      note_error($sformatf("FAILED t=%0t wr_addr expected %0d got %0d",
                           $time, exp_addr, wr_addr));
    if (wr_data !== exp_data)
      note_error($sformatf("FAILED t=%0t wr_data expected %h got %h",
                           $time, exp_data, wr_data));
  endtask

  task automatic take_input();
    if (in_valid !== 1'b1) return;
    group[slot*FP16_W +: FP16_W] = to_fp16(in_data);
    if (in_last || slot == BUF_LOC_SIZE - 1) begin
      addr_q.push_back(next_addr);
      data_q.push_back(group);
      next_addr = in_last ? '0 : next_addr + 1'b1;
      group     = '0;
      slot      = 0;
    end else begin
      slot++;
    end
  endtask

  // inputs are stable here and hold what the next edge takes
  always @(negedge clk) begin
    if (arst_n !== 1'b1) begin
      if (wr_en === 1'b1) note_error($sformatf("t=%0t wr_en high during reset", $time));
      addr_q.delete();   // words in flight die with the reset
      data_q.delete();
      group     = '0;
      slot      = 0;
      next_addr = '0;
    end else begin
      check_write();
      take_input();
    end
  end

  function automatic int pending();
    return addr_q.size();
  endfunction

  task automatic end_test(input string name);
    if (slot != 0)
      note_error($sformatf("test %s left %0d words in an unfinished location", name, slot));
    tests++;
    if (test_errors == 0)
      $display("test %0d %s: ok, %0d writes", tests, name, test_writes);
    else
      $display("test %0d %s: %0d errors in %0d writes", tests, name, test_errors, test_writes);
    test_errors = 0;
    test_writes = 0;
  endtask

endmodule

`default_nettype wire

//--- bench/conv_props.sv
`default_nettype none

// strobe latency through one pipeline block
module conv_props #(
  parameter int LAT   = 1,
  parameter int GROUP = 1    // input strobes per output strobe
) (
  input logic clk,
  input logic arst_n,
  input logic src,        // strobe into the block
  input logic src_last,   // last word of a sentence
  input logic dst         // strobe out of it
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fails = 0;
  int          seen;
  logic        done;

  // own count of the words in the current group
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      seen <= 0;
    end else if (done) begin
      seen <= 0;
    end else if (src) begin
      seen <= seen + 1;
    end
  end

  // input strobe that completes a group or a sentence
  assign done = src && (src_last || seen == GROUP - 1);

  a_latency : assert property (@(posedge clk) disable iff (!arst_n) done |-> ##LAT dst)
    else begin
      $error("strobe did not come out %0d cycles later", LAT);
      fails++;
    end

  // also rules out a wr_en held longer than one cycle
  a_no_extra : assert property (@(posedge clk) disable iff (!arst_n) dst |-> $past(done, LAT))
    else begin
      $error("output strobe without an input strobe %0d cycles before", LAT);
      fails++;
    end

  a_quiet_in_reset : assert property (@(posedge clk) !arst_n |-> !dst)
    else begin
      $error("output strobe while in reset");
      fails++;
    end

endmodule

bind int_to_fp16 conv_props #(.LAT(2)) u_props (
  .clk(clk), .arst_n(arst_n), .src(in_valid), .src_last(in_last), .dst(out_valid)
);

bind word_packer conv_props #(.LAT(1), .GROUP(fp16_pkg::BUF_LOC_SIZE)) u_props (
  .clk(clk), .arst_n(arst_n), .src(in_valid), .src_last(in_last), .dst(wr_en)
);

`default_nettype wire

//--- bench/tb_conv_top.sv
`default_nettype none

module tb_conv_top import fp16_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int SEED    = 50194;
  localparam int DRAIN   = 10;
  // reset, edge, full groups, gaps, early last, sentences, mid reset
  localparam int RUN_CYC = 17 + (8 + DRAIN) + (80 + DRAIN) + (60 * 4 + DRAIN)
                         + (16 + DRAIN) + (36 + DRAIN) + (20 + DRAIN);
  localparam int MAX_CYC = 2 * RUN_CYC + 100;

  logic      clk;
  logic      arst_n;
  logic      rst_req;
  logic      in_valid;
  int_word_t in_data;
  logic      in_last;
  logic      wr_en;
  buf_addr_t wr_addr;
  buf_word_t wr_data;
  int        cycles = 0;
  int        fails;

  clock_gen u_clk (.rst_req(rst_req), .clk(clk), .arst_n(arst_n));

  conv_top UUT (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_valid (in_valid),
    .in_data  (in_data),
    .in_last  (in_last),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data)
  );

  conv_checker u_check (.*);

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYC) begin
      $display("timeout: run still busy after %0d cycles", cycles);
      $display("Testbench failed");
      $finish;
    end
  end

  function automatic int_word_t rand_score();
    int_word_t raw;
    raw = int_word_t'($urandom);
    return raw >>> $urandom_range(15);   // spread over all exponents
  endfunction

  task automatic send_word(input int_word_t data, input logic last);
    @(posedge clk);
    #2;
    in_valid = 1'b1;
    in_data  = data;
    in_last  = last;
  endtask

  task automatic idle(input int cnt);
    repeat (cnt) begin
      @(posedge clk);
      #2;
      in_valid = 1'b0;
      in_last  = 1'($urandom_range(1));   // junk, ignored without valid
      in_data  = int_word_t'($urandom);
    end
  endtask

  task automatic finish_test(input string name);
    idle(1);
    while (u_check.pending() != 0) idle(1);
    idle(2);
    u_check.end_test(name);
  endtask

  initial begin
    int_word_t edge_vals[8];
    int        len;
    rst_req   = 1'b0;
    in_valid  = 1'b0;
    in_data   = '0;
    in_last   = 1'b0;
    edge_vals = '{0, 1, -1, 32767, -32768, 2047, 2048, 4097};
    void'($urandom(SEED));
    wait (arst_n === 1'b1);

    foreach (edge_vals[i]) send_word(edge_vals[i], 1'b0);
    finish_test("edge values");

    repeat (80) send_word(rand_score(), 1'b0);   // wraps the address
    finish_test("back to back groups");

    repeat (60) begin
      idle($urandom_range(3));
      send_word(rand_score(), 1'b0);
    end
    finish_test("random gaps");

    for (int k = 1; k <= 3; k++) begin
      repeat (k - 1) send_word(rand_score(), 1'b0);
      send_word(rand_score(), 1'b1);
      idle(2);
    end
    repeat (4) send_word(rand_score(), 1'b0);
    finish_test("early last");

    repeat (6) begin
      len = $urandom_range(6, 1);
      repeat (len - 1) send_word(rand_score(), 1'b0);
      send_word(rand_score(), 1'b1);
    end
    finish_test("back to back sentences");

    repeat (10) send_word(rand_score(), 1'b0);
    @(posedge clk);
    #2;
    in_valid = 1'b0;
    rst_req  = 1'b1;   // second group and two words still in flight
    idle(3);
    rst_req = 1'b0;
    repeat (4) send_word(rand_score(), 1'b0);
    send_word(rand_score(), 1'b1);
    finish_test("reset mid stream");

    fails = u_check.errors + UUT.u_convert.u_props.fails + UUT.u_packer.u_props.fails;
    $display("%0d tests, %0d writes, %0d check errors, %0d assertion failures",
             u_check.tests, u_check.writes, u_check.errors,
             UUT.u_convert.u_props.fails + UUT.u_packer.u_props.fails);
    if (fails == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
common/fp16_pkg.sv
common/norm_if.sv
logic/lead_zero_count.sv
fp16_convert/int_normalize.sv
fp16_convert/round_pack.sv
fp16_convert/int_to_fp16.sv
logic/word_packer.sv
logic/conv_top.sv
bench/clock_gen.sv
bench/conv_checker.sv
bench/conv_props.sv
bench/tb_conv_top.sv

//--- Bender.yml
package:
  name: conv_top

sources:
  # design, in compile order
  - common/fp16_pkg.sv
  - common/norm_if.sv
  - logic/lead_zero_count.sv
  - fp16_convert/int_normalize.sv
  - fp16_convert/round_pack.sv
  - fp16_convert/int_to_fp16.sv
  - logic/word_packer.sv
  - logic/conv_top.sv
  # testbench
  - target: simulation
    files:
      - bench/clock_gen.sv
      - bench/conv_checker.sv
      - bench/conv_props.sv
      - bench/tb_conv_top.sv
